/* logic/mul_cfg_pkg.sv */
package mul_cfg_pkg;

	// ****************************************
	// operand and product widths
	// ****************************************

	// fixed by the core's XLEN
	localparam int xlen = 64;

	// low half taken by the word-mode ops (mulw)
	localparam int word_width = 32;

	// sign or zero extended operand, kept even for radix-4 windows
	localparam int ext_width = xlen + 2;

	// radix-4 iterations, two extended bits per step
	localparam int full_steps = ext_width / 2;
	// 34 extended bits cover a sign-extended 32-bit multiplier
	localparam int word_steps = 17;

	// step counter must be able to reach full_steps
	localparam int step_width = $clog2(full_steps + 1);

endpackage

/* logic/mul_op_pkg.sv */
package mul_op_pkg;

	import mul_cfg_pkg::*;

	// ****************************************
	// request encoding
	// ****************************************

	// signedness of the two operands
	// bit 1 -> multiplicand signed, bit 0 -> multiplier signed
	typedef logic [1:0] mul_sign_t;

	// bit positions inside mul_sign_t
	localparam int sign_cand  = 1;
	localparam int sign_plier = 0;

	// ****************************************
	// product word
	// ****************************************

	// accumulator adds through the full view
	// formatter and top ports read the halves
	typedef union packed {
		logic [2*xlen-1:0] full;
		struct packed {
			logic [xlen-1:0] hi;
			logic [xlen-1:0] lo;
		} half;
	} product_u;

endpackage

/* logic/booth_pp_if.sv */
interface booth_pp_if
	import mul_cfg_pkg::*;
();

	// current three-bit booth window, multiplier bits [2i+1:2i-1]
	logic [2:0]           window;
	// extended multiplicand, held for the whole operation
	logic [ext_width-1:0] multiplicand;
	// selected multiple, one's complement when negate is set
	logic [ext_width:0]   pprod;
	// plus-one still owed at the window's weight
	logic                 negate;

	// core side owns the window and the operand
	modport core (
		output window,
		output multiplicand,
		input  pprod,
		input  negate
	);

	// encoder side answers combinationally
	modport encoder (
		input  window,
		input  multiplicand,
		output pprod,
		output negate
	);

endinterface

/* logic/booth_encoder.sv */
module booth_encoder
	import mul_cfg_pkg::*;
(
	booth_pp_if.encoder pp
);

	// multiples of the multiplicand, one bit wider for 2x
	logic [ext_width:0] one_x;
	logic [ext_width:0] two_x;
	// magnitude before inversion
	logic [ext_width:0] mag;
	logic               neg;

	// 1x keeps the sign in the extra bit
	assign one_x = {pp.multiplicand[ext_width-1], pp.multiplicand};
	// 2x is a plain left shift, top bit already a sign copy
	assign two_x = {pp.multiplicand, 1'b0};

	// ****************************************
	// radix-4 booth recoding
	// ****************************************
	always_comb begin
		mag = '0;
		neg = 1'b0;
		case (pp.window)
			// +1x
			3'b001,
			3'b010: begin
				mag = one_x;
			end
			// +2x
			3'b011: begin
				mag = two_x;
			end
			// -2x
			3'b100: begin
				mag = two_x;
				neg = 1'b1;
			end
			// -1x
			3'b101,
			3'b110: begin
				mag = one_x;
				neg = 1'b1;
			end
			// 000 and 111 select zero
			default: begin
				mag = '0;
				neg = 1'b0;
			end
		endcase
	end

	// only invert here, the +1 is added by the core accumulator
	assign pp.pprod  = neg ? ~mag : mag;
	assign pp.negate = neg;

endmodule

/* logic/booth_multiplier.sv */
module booth_multiplier
	import mul_cfg_pkg::*;
	import mul_op_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            mul_valid,
	input  logic            flush,
	input  logic            mulw,
	input  mul_sign_t       mul_signed,
	input  logic [xlen-1:0] multiplicand,
	input  logic [xlen-1:0] multiplier,
	output logic            mul_ready,
	output logic            done,
	output logic            word,
	output product_u        product,
	booth_pp_if.core        pp
);

	// control
	logic                  busy;
	logic                  accept;
	logic                  last_step;
	logic [step_width-1:0] step_cnt;

	// operands
	logic [ext_width-1:0]  cand_ext;
	logic [ext_width-1:0]  plier_ext;
	logic [ext_width-1:0]  mcand_q;
	// multiplier plus the implicit zero below bit 0
	logic [ext_width:0]    mplier_q;

	// accumulation
	logic [2*xlen-1:0]     pp_wide;
	logic [2*xlen-1:0]     addend;

	// ****************************************
	// operand extension
	// ****************************************

	// word mode always sign-extends from bit 31, like MULW
	function automatic logic [ext_width-1:0] extend_operand(
		input logic [xlen-1:0] value,
		input logic            is_signed,
		input logic            word_mode
	);
		logic fill;
		if (word_mode) begin
			fill = value[word_width-1];
			return {{(ext_width-word_width){fill}}, value[word_width-1:0]};
		end
		fill = is_signed & value[xlen-1];
		return {{(ext_width-xlen){fill}}, value};
	endfunction

	assign cand_ext  = extend_operand(multiplicand, mul_signed[sign_cand], mulw);
	assign plier_ext = extend_operand(multiplier, mul_signed[sign_plier], mulw);

	// a request together with flush is dropped
	assign accept = mul_valid & mul_ready & ~flush;

	// word mode stops once the 34 meaningful bits are consumed
	assign last_step = word ? (step_cnt == step_width'(word_steps - 1))
		: (step_cnt == step_width'(full_steps - 1));

	// ****************************************
	// control state
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			mul_ready <= 1'b1;
			done      <= 1'b0;
			step_cnt  <= '0;
		end else begin
			// done is a single pulse unless set below
			done <= 1'b0;
			if (flush) begin
				// abort, nothing reaches the formatter
				busy      <= 1'b0;
				mul_ready <= 1'b1;
			end else if (accept) begin
				busy      <= 1'b1;
				mul_ready <= 1'b0;
				step_cnt  <= '0;
			end else if (busy) begin
				step_cnt <= step_cnt + 1'b1;
				if (last_step) begin
					// result ready next cycle, core free again
					busy      <= 1'b0;
					mul_ready <= 1'b1;
					done      <= 1'b1;
				end
			end
		end
	end

	// ****************************************
	// datapath
	// ****************************************

	// window is the low three bits of the shifting multiplier
	assign pp.window       = mplier_q[2:0];
	assign pp.multiplicand = mcand_q;

	// sign-extend the partial product and add the owed +1
	assign pp_wide = {{(2*xlen-ext_width-1){pp.pprod[ext_width]}}, pp.pprod}
		+ (2*xlen)'(pp.negate);
	// weight of this window is 4^step
	assign addend = pp_wide << {step_cnt, 1'b0};

	always_ff @(posedge clk) begin
		if (accept) begin
			mcand_q      <= cand_ext;
			mplier_q     <= {plier_ext, 1'b0};
			word         <= mulw;
			product.full <= '0;
		end else if (busy) begin
			// modulo 2^128 sum, high bits of late terms fall off
			product.full <= product.full + addend;
			// arithmetic shift keeps the top windows as sign copies
			mplier_q     <= {{2{mplier_q[ext_width]}}, mplier_q[ext_width:2]};
		end
	end

	// ****************************************
	// checks
	// ****************************************

	// ready register and busy register stay exclusive
	assert property (@(posedge clk) disable iff (rst) !(mul_ready && busy));

	// one done per operation
	assert property (@(posedge clk) disable iff (rst) done |=> !done);

	// counter stops at full_steps after the final iteration
	assert property (@(posedge clk) disable iff (rst) step_cnt <= step_width'(full_steps));

endmodule

/* logic/mul_result_format.sv */
module mul_result_format
	import mul_cfg_pkg::*;
	import mul_op_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            done,
	input  logic            word,
	input  product_u        product,
	output logic            out_valid,
	output logic [xlen-1:0] result_hi,
	output logic [xlen-1:0] result_lo
);

	// low word sign-extended to xlen
	logic [xlen-1:0] lo_word;
	// values captured on done
	logic [xlen-1:0] hi_next;
	logic [xlen-1:0] lo_next;

	// ****************************************
	// word-mode sign extension
	// ****************************************

	assign lo_word = {{(xlen-word_width){product.half.lo[word_width-1]}},
		product.half.lo[word_width-1:0]};

	// full mode passes both halves through
	assign lo_next = word ? lo_word : product.half.lo;
	// word mode hi is all copies of the sign of lo
	assign hi_next = word ? {xlen{lo_word[xlen-1]}} : product.half.hi;

	// ****************************************
	// output register
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			result_hi <= '0;
			result_lo <= '0;
		end else begin
			out_valid <= done;
			// hold until the next result
			if (done) begin
				result_hi <= hi_next;
				result_lo <= lo_next;
			end
		end
	end

	// valid is a one-cycle strobe, nobody acknowledges it
	assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid);

endmodule

/* logic/mul_unit.sv */
module mul_unit
	import mul_cfg_pkg::*;
	import mul_op_pkg::*;
(
	input  logic            clk,
	input  logic            rst,

	// request side
	input  logic            mul_valid,
	input  logic            flush,
	input  logic            mulw,
	input  mul_sign_t       mul_signed,
	input  logic [xlen-1:0] multiplicand,
	input  logic [xlen-1:0] multiplier,
	output logic            mul_ready,

	// result side, no back-pressure
	output logic            out_valid,
	output logic [xlen-1:0] result_hi,
	output logic [xlen-1:0] result_lo
);

	// core to formatter
	logic     done;
	logic     word;
	product_u product;

	// window and partial product between core and encoder
	booth_pp_if pp_bus ();

	// ****************************************
	// iterative core
	// ****************************************
	booth_multiplier u_core (
		.clk          (clk),
		.rst          (rst),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.done         (done),
		.word         (word),
		.product      (product),
		.pp           (pp_bus.core)
	);

	// combinational booth recoder
	booth_encoder u_encoder (
		.pp (pp_bus.encoder)
	);

	// ****************************************
	// result register
	// ****************************************
	mul_result_format u_format (
		.clk       (clk),
		.rst       (rst),
		.done      (done),
		.word      (word),
		.product   (product),
		.out_valid (out_valid),
		.result_hi (result_hi),
		.result_lo (result_lo)
	);

endmodule

/* sim/mul_unit_tb.sv */
module mul_unit_tb
	import mul_cfg_pkg::*;
	import mul_op_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	// wait limits in clock cycles
	localparam int ready_limit = 2 * full_steps + 8;
	localparam int drain_limit = 4 * full_steps + 8;

	logic            clk;
	logic            rst;
	logic            mul_valid;
	logic            flush;
	logic            mulw;
	mul_sign_t       mul_signed;
	logic [xlen-1:0] multiplicand;
	logic [xlen-1:0] multiplier;
	logic            mul_ready;
	logic            out_valid;
	logic [xlen-1:0] result_hi;
	logic [xlen-1:0] result_lo;

	// expected {hi, lo} in issue order
	logic [2*xlen-1:0] exp_q[$];
	logic [2*xlen-1:0] expected;
	int                errors;
	int                issued;
	int                received;
	int                stray;

	// zero, one, all ones, most negative, largest positive
	logic [xlen-1:0]   corner[5];

	mul_unit mul_unit_i (
		.clk          (clk),
		.rst          (rst),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	always #5 clk = ~clk;

	// ****************************************
	// reference model
	// ****************************************

	// plain signed 128-bit multiply of the extended operands
	function automatic logic [2*xlen-1:0] ref_product(
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b,
		input logic            w,
		input mul_sign_t       s
	);
		logic signed [2*xlen-1:0] ea;
		logic signed [2*xlen-1:0] eb;
		logic signed [2*xlen-1:0] prod;
		logic [xlen-1:0]          lo;
		if (w) begin
			// MULW: low words, always signed, upper bits ignored
			ea = {{(2*xlen-32){a[31]}}, a[31:0]};
			eb = {{(2*xlen-32){b[31]}}, b[31:0]};
			prod = ea * eb;
			lo = {{(xlen-32){prod[31]}}, prod[31:0]};
			return {{xlen{lo[xlen-1]}}, lo};
		end
		// upper bit of s -> multiplicand signed
		ea = s[1] ? {{xlen{a[xlen-1]}}, a} : {{xlen{1'b0}}, a};
		eb = s[0] ? {{xlen{b[xlen-1]}}, b} : {{xlen{1'b0}}, b};
		prod = ea * eb;
		return prod;
	endfunction

	function automatic logic [xlen-1:0] rand_word();
		return {$urandom(), $urandom()};
	endfunction

	// ****************************************
	// run control
	// ****************************************

	task automatic end_run();
		$display("errors %0d, issued %0d, received %0d", errors, issued, received);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	// hold the request until the core takes it
	task automatic present(
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b,
		input logic            w,
		input mul_sign_t       s
	);
		int cnt;
		@(posedge clk);
		mul_valid    <= 1'b1;
		multiplicand <= a;
		multiplier   <= b;
		mulw         <= w;
		mul_signed   <= s;
		cnt = 0;
		@(negedge clk);
		while (!mul_ready) begin
			cnt++;
			if (cnt > ready_limit) begin
				errors++;
				$display("timeout at %0t: mul_ready never came back for a request", $time);
				end_run();
			end
			@(negedge clk);
		end
		// ready seen mid-cycle, so this edge accepts
		@(posedge clk);
		mul_valid <= 1'b0;
	endtask

	task automatic send(
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b,
		input logic            w,
		input mul_sign_t       s
	);
		present(a, b, w, s);
		exp_q.push_back(ref_product(a, b, w, s));
		issued++;
	endtask

	// wait for every outstanding result
	task automatic drain();
		int cnt;
		cnt = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			cnt++;
			if (cnt > drain_limit) begin
				errors++;
				$display("timeout at %0t: out_valid missing for %0d results", $time,
					exp_q.size());
				end_run();
			end
		end
	endtask

	// ****************************************
	// compare process
	// ****************************************

	// outputs change on the rising edge, sample on the falling one
	always @(negedge clk) begin
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("out_valid at %0t with no request outstanding", $time);
			end else begin
				expected = exp_q.pop_front();
				received++;
				if (result_hi !== expected[2*xlen-1:xlen]) begin
					errors++;
					$display("Error at %0t: result_hi expected %h got %h", $time,
						expected[2*xlen-1:xlen], result_hi);
				end
				if (result_lo !== expected[xlen-1:0]) begin
					errors++;
					$display("Error at %0t: result_lo expected %h got %h", $time,
						expected[xlen-1:0], result_lo);
				end
			end
		end
	end

	// ****************************************
	// stimulus
	// ****************************************
	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		mul_valid    = 1'b0;
		flush        = 1'b0;
		mulw         = 1'b0;
		mul_signed   = 2'b00;
		multiplicand = '0;
		multiplier   = '0;
		errors       = 0;
		issued       = 0;
		received     = 0;
		stray        = 0;
		corner[0]    = '0;
		corner[1]    = {{(xlen-1){1'b0}}, 1'b1};
		corner[2]    = '1;
		corner[3]    = {1'b1, {(xlen-1){1'b0}}};
		corner[4]    = {1'b0, {(xlen-1){1'b1}}};
		void'($urandom(79745));

		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// idle state straight after reset
		@(negedge clk);
		if (mul_ready !== 1'b1) begin
			errors++;
			$display("Error at %0t: mul_ready expected 1 got %b", $time, mul_ready);
		end
		if (out_valid !== 1'b0) begin
			errors++;
			$display("Error at %0t: out_valid expected 0 got %b", $time, out_valid);
		end
		if (result_hi !== '0) begin
			errors++;
			$display("Error at %0t: result_hi expected %h got %h", $time, {xlen{1'b0}},
				result_hi);
		end
		if (result_lo !== '0) begin
			errors++;
			$display("Error at %0t: result_lo expected %h got %h", $time, {xlen{1'b0}},
				result_lo);
		end

		// random full-mode operands, all signedness codes
		for (int s = 0; s < 4; s++) begin
			repeat (8) begin
				send(rand_word(), rand_word(), 1'b0, mul_sign_t'(s));
				drain();
			end
		end

		// every corner pair under every signedness
		for (int s = 0; s < 4; s++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					send(corner[i], corner[j], 1'b0, mul_sign_t'(s));
					drain();
				end
			end
		end

		// word mode, same low words with two sets of upper bits
		repeat (16) begin
			logic [xlen-1:0] a;
			logic [xlen-1:0] b;
			a = rand_word();
			b = rand_word();
			send(a, b, 1'b1, mul_sign_t'($urandom_range(3)));
			send({$urandom(), a[31:0]}, {$urandom(), b[31:0]}, 1'b1,
				mul_sign_t'($urandom_range(3)));
			drain();
		end
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				send(corner[i], corner[j], 1'b1, 2'b11);
				drain();
			end
		end

		// flush in the middle of an operation
		present(rand_word(), rand_word(), 1'b0, 2'b11);
		repeat (5) @(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		if (mul_ready !== 1'b1) begin
			errors++;
			$display("Error at %0t: mul_ready expected 1 got %b", $time, mul_ready);
		end
		repeat (full_steps + 4) begin
			@(negedge clk);
			if (out_valid)
				stray++;
		end
		if (stray != 0) begin
			errors++;
			$display("flushed operation still produced %0d out_valid pulses", stray);
		end
		send(rand_word(), rand_word(), 1'b0, 2'b01);
		drain();

		// back-to-back, issued as soon as ready returns
		repeat (20) begin
			send(rand_word(), rand_word(), 1'($urandom_range(1)),
				mul_sign_t'($urandom_range(3)));
		end
		drain();

		// quiet window, a repeated result shows up as an unexpected out_valid
		repeat (full_steps + 4) @(negedge clk);
		end_run();
	end

endmodule

/* project.f */
logic/mul_cfg_pkg.sv
logic/mul_op_pkg.sv
logic/booth_pp_if.sv
logic/booth_encoder.sv
logic/booth_multiplier.sv
logic/mul_result_format.sv
logic/mul_unit.sv
sim/mul_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the multiply unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f project.f \
	--top-module mul_unit_tb \
	-o mul_unit_sim

./obj_dir/mul_unit_sim 2>&1 | tee sim.log

# the log decides pass or fail
if grep -qx "Test passed" sim.log; then
	echo "simulation ok"
	exit 0
else
	echo "simulation reported failure"
	exit 1
fi
